//--- compile.f
src/copy_cfg_pkg.sv
src/copy_types_pkg.sv
src/req_counter.sv
src/nested_addr_gen.sv
src/copy_sequencer.sv
src/write_stage.sv
src/strided_copy.sv
tests/strided_copy_checker.sv
tests/tb_strided_copy.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_strided_copy
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Test passed
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

SOURCES := $(wildcard src/*.sv tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_strided_copy.sv
`default_nettype none

module tb_strided_copy;

    localparam int CLK_PERIOD   = 100;
    localparam int RST_CYC      = 8;
    localparam int REQ_W        = 12;    // narrower than the default count width
    localparam int AW           = copy_cfg_pkg::ADDR_W;
    localparam int DW           = copy_cfg_pkg::DATA_W;
    localparam int N_2D         = 12;
    localparam int N_6D         = 30;
    localparam int N_ONE        = 1;
    localparam int TEST_CYC     = 24;    // setup, return latency tail and quiet window
    localparam int WATCHDOG_CYC = RST_CYC + 6 + N_2D + N_6D + N_ONE + 4 * TEST_CYC + 100;

    logic                          clk       = 1'b0;
    logic                          reset_n;
    logic                          init_pulse;
    logic [REQ_W-1:0]              areq_num;
    copy_types_pkg::addr_pattern_t rd_pattern;
    copy_types_pkg::addr_pattern_t wr_pattern;
    logic [DW-1:0]                 rdata     = '0;
    logic                          rdata_vld = 1'b0;
    copy_types_pkg::rd_req_t       rd_req;
    copy_types_pkg::wr_beat_t      wr;
    logic                          finish;

    int cyc         = 0;
    int init_cyc    = 0;
    int rd_idx      = 0;
    int last_wr_cyc = 0;
    int last_due    = 0;

    logic [AW-1:0] exp_rd[$];
    logic [AW-1:0] exp_wr_addr[$];
    logic [DW-1:0] exp_wr_data[$];
    logic [AW-1:0] pend_addr[$];    // reads waiting for their data
    int            pend_due[$];

    strided_copy #(.REQ_W(REQ_W)) u_dut (
        .clk
    ,   .reset_n
    ,   .init_pulse
    ,   .areq_num
    ,   .rd_pattern
    ,   .wr_pattern
    ,   .rdata
    ,   .rdata_vld
    ,   .rd_req
    ,   .wr
    ,   .finish
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // k-th address of a pattern with dim 0 fastest
    function automatic logic [AW-1:0] pattern_addr(copy_types_pkg::addr_pattern_t p, int k);
        logic [AW-1:0] a;
        int            rem;
        int            idx;
        a   = p.base;
        rem = k;
        for (int d = 0; d < copy_cfg_pkg::NUM_DIMS; d++) begin
            if (p.size[d] > 1) begin
                idx = rem % p.size[d];
                rem = rem / p.size[d];
                a   = a + AW'(idx) * p.stride[d];    // wraps at the address width
            end
        end
        return a;
    endfunction

    function automatic logic [DW-1:0] word_of(logic [AW-1:0] a);
        return {(DW / AW){a}};
    endfunction

    function automatic copy_types_pkg::addr_pattern_t pattern_2d(
        logic [AW-1:0] base,
        logic [AW-1:0] s0,
        logic [AW-1:0] st0,
        logic [AW-1:0] s1,
        logic [AW-1:0] st1
    );
        copy_types_pkg::addr_pattern_t p;
        p           = '0;
        p.base      = base;
        p.size[0]   = s0;
        p.stride[0] = st0;
        p.size[1]   = s1;
        p.stride[1] = st1;
        return p;
    endfunction

    task automatic flag_mismatch(string sig, logic [DW-1:0] got, logic [DW-1:0] exp);
        $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
        $display("Test failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_with(string what);
        $display("ERROR t=%0t %s", $time, what);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic outputs_idle();
        assert (rd_req.vld === 1'b0) else flag_mismatch("rd_req.vld", rd_req.vld, '0);
        assert (wr.vld === 1'b0) else flag_mismatch("wr.vld", wr.vld, '0);
        assert (finish === 1'b0) else flag_mismatch("finish", finish, '0);
    endtask

    // port monitor that also queues each read for the memory model
    always @(negedge clk) begin
        logic [AW-1:0] ea;
        int            due;
        if (init_pulse) begin
            init_cyc = cyc;
            rd_idx   = 0;
        end
        if (rd_req.vld) begin
            assert (exp_rd.size() != 0) else abort_with("read request beyond areq_num");
            ea = exp_rd.pop_front();
            assert (rd_req.addr === ea) else flag_mismatch("rd_req.addr", rd_req.addr, ea);
            assert (cyc == init_cyc + 2 + rd_idx)
                else abort_with("read requests not in consecutive cycles after init_pulse");
            rd_idx++;
            due = cyc + 1 + int'($urandom % 4);
            if (due <= last_due) due = last_due + 1;    // keeps returns in order
            last_due = due;
            pend_addr.push_back(rd_req.addr);
            pend_due.push_back(due);
        end
        if (wr.vld) begin
            assert (exp_wr_addr.size() != 0) else abort_with("write beat beyond areq_num");
            assert (wr.addr === exp_wr_addr[0])
                else flag_mismatch("wr.addr", wr.addr, exp_wr_addr[0]);
            assert (wr.data === exp_wr_data[0])
                else flag_mismatch("wr.data", wr.data, exp_wr_data[0]);
            void'(exp_wr_addr.pop_front());
            void'(exp_wr_data.pop_front());
            last_wr_cyc = cyc;
        end
        assert (u_dut.u_checker.fails == 0) else abort_with("a bound protocol assertion failed");
    end

    // memory model returns the read address repeated
    always @(posedge clk) begin
        if (pend_addr.size() != 0 && pend_due[0] <= cyc + 1) begin
            rdata     <= word_of(pend_addr[0]);
            rdata_vld <= 1'b1;
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end else begin
            rdata_vld <= 1'b0;
        end
    end

    task automatic check_reset_idle();
        repeat (RST_CYC) begin
            @(negedge clk);
            outputs_idle();
        end
        @(posedge clk);
        reset_n <= 1'b1;
        repeat (6) begin    // still idle without init_pulse
            @(negedge clk);
            outputs_idle();
        end
    endtask

    task automatic run_copy(
        copy_types_pkg::addr_pattern_t rd_p,
        copy_types_pkg::addr_pattern_t wr_p,
        int                            n
    );
        int fin_cyc;
        int waited;
        for (int k = 0; k < n; k++) begin
            exp_rd.push_back(pattern_addr(rd_p, k));
            exp_wr_addr.push_back(pattern_addr(wr_p, k));
            exp_wr_data.push_back(word_of(pattern_addr(rd_p, k)));
        end
        @(posedge clk);
        rd_pattern <= rd_p;
        wr_pattern <= wr_p;
        areq_num   <= REQ_W'(n);
        init_pulse <= 1'b1;
        @(posedge clk);
        init_pulse <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (finish !== 1'b1 && waited < n + 16);
        assert (finish === 1'b1) else abort_with("finish did not pulse after the copy");
        fin_cyc = cyc;
        assert (exp_rd.size() == 0) else abort_with("fewer read requests than areq_num");
        assert (exp_wr_addr.size() == 0) else abort_with("fewer write beats than areq_num");
        if (n == 0) begin
            assert (fin_cyc == init_cyc + 2)
                else flag_mismatch("finish cycle", fin_cyc, init_cyc + 2);
        end else begin
            assert (fin_cyc == last_wr_cyc + 1)
                else flag_mismatch("finish cycle", fin_cyc, last_wr_cyc + 1);
        end
        repeat (6) begin
            @(negedge clk);
            outputs_idle();
        end
    endtask

    initial begin
        copy_types_pkg::addr_pattern_t p6;
        void'($urandom(63));
        reset_n    = 1'b0;
        init_pulse = 1'b0;
        areq_num   = '0;
        rd_pattern = '0;
        wr_pattern = '0;
        check_reset_idle();
        // 4x3 block read into a linear write
        run_copy(pattern_2d(16'h0100, 16'd4, 16'h0040, 16'd3, 16'h0400),
                 pattern_2d(16'h8000, 16'd12, 16'h0040, 16'd0, 16'h0000), N_2D);
        // dims 1 and 3 unused and dim 5 listed first
        p6        = '0;
        p6.base   = 16'hff00;
        p6.size   = {16'd4, 16'd2, 16'd0, 16'd3, 16'd1, 16'd2};
        p6.stride = {16'h0010, 16'h4000, 16'h0080, 16'h0200, 16'h1000, 16'h0040};
        // write pattern of 10 wraps three times
        run_copy(p6, pattern_2d(16'h2000, 16'd5, 16'h0040, 16'd2, 16'h0800), N_6D);
        run_copy(p6, pattern_2d(16'h4000, 16'd8, 16'h0040, 16'd0, 16'h0000), 0);
        run_copy(pattern_2d(16'h0300, 16'd2, 16'h0040, 16'd0, 16'h0000),
                 pattern_2d(16'h6000, 16'd2, 16'h0040, 16'd0, 16'h0000), N_ONE);
        if (u_dut.u_checker.fails == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "protocol assertions failed");
        end
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("ERROR t=%0t run did not complete within %0d cycles", $time, WATCHDOG_CYC);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule : tb_strided_copy

`default_nettype wire

//--- tests/strided_copy_checker.sv
`default_nettype none

module strided_copy_checker (
    input logic                     clk,
    input logic                     reset_n,
    input logic                     rdata_vld,
    input copy_types_pkg::rd_req_t  rd_req,
    input copy_types_pkg::wr_beat_t wr,
    input logic                     finish
);

    int unsigned fails = 0;    // failed assertions so far

    finish_single: assert property (@(posedge clk) disable iff (!reset_n)
        finish |=> !finish)
    else begin
        fails++;
        $error("finish held for more than one cycle");
    end

    // each returned word becomes a write beat one cycle later
    wr_after_rdata: assert property (@(posedge clk) disable iff (!reset_n)
        rdata_vld |=> wr.vld)
    else begin
        fails++;
        $error("no write beat one cycle after rdata_vld");
    end

    wr_has_rdata: assert property (@(posedge clk) disable iff (!reset_n)
        wr.vld |-> $past(rdata_vld))
    else begin
        fails++;
        $error("write beat without rdata_vld in the cycle before");
    end

    no_rd_after_finish: assert property (@(posedge clk) disable iff (!reset_n)
        finish |=> !rd_req.vld)
    else begin
        fails++;
        $error("read request in the cycle after finish");
    end

endmodule : strided_copy_checker

bind strided_copy strided_copy_checker u_checker (
    .clk
,   .reset_n
,   .rdata_vld
,   .rd_req
,   .wr
,   .finish
);

`default_nettype wire

//--- src/strided_copy.sv
`default_nettype none

module strided_copy #(
    parameter int REQ_W = copy_cfg_pkg::REQ_W_DEFAULT
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            init_pulse,
    input  logic [REQ_W-1:0]                areq_num,
    input  copy_types_pkg::addr_pattern_t   rd_pattern,
    input  copy_types_pkg::addr_pattern_t   wr_pattern,
    input  logic [copy_cfg_pkg::DATA_W-1:0] rdata,
    input  logic                            rdata_vld,
    output copy_types_pkg::rd_req_t         rd_req,
    output copy_types_pkg::wr_beat_t        wr,
    output logic                            finish
);

    logic                            rd_step;
    logic [copy_cfg_pkg::ADDR_W-1:0] rd_addr;
    logic                            rd_addr_vld;
    logic [copy_cfg_pkg::ADDR_W-1:0] wr_addr;
    logic                            wr_addr_vld;
    logic                            wr_done;

    copy_sequencer #(.REQ_W(REQ_W)) u_seq (
        .clk
    ,   .reset_n
    ,   .init_pulse
    ,   .areq_num
    ,   .wr_done
    ,   .rd_step
    ,   .finish
    );

    nested_addr_gen u_rd_gen (
        .clk
    ,   .reset_n
    ,   .init_pulse
    ,   .pattern  (rd_pattern)
    ,   .step     (rd_step)
    ,   .addr     (rd_addr)
    ,   .addr_vld (rd_addr_vld)
    );

    assign rd_req = '{addr: rd_addr, vld: rd_addr_vld};

    // one write address per returned word
    nested_addr_gen u_wr_gen (
        .clk
    ,   .reset_n
    ,   .init_pulse
    ,   .pattern  (wr_pattern)
    ,   .step     (rdata_vld)
    ,   .addr     (wr_addr)
    ,   .addr_vld (wr_addr_vld)
    );

    write_stage u_wr_stage (
        .clk
    ,   .reset_n
    ,   .rdata
    ,   .rdata_vld
    ,   .waddr     (wr_addr)
    ,   .waddr_vld (wr_addr_vld)
    ,   .wr
    ,   .wr_done
    );

endmodule : strided_copy

`default_nettype wire

//--- src/write_stage.sv
`default_nettype none

module write_stage (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic [copy_cfg_pkg::DATA_W-1:0] rdata,
    input  logic                            rdata_vld,
    input  logic [copy_cfg_pkg::ADDR_W-1:0] waddr,
    input  logic                            waddr_vld,
    output copy_types_pkg::wr_beat_t        wr,
    output logic                            wr_done
);

    logic [copy_cfg_pkg::DATA_W-1:0] data_q;
    logic                            beat_q;    // a word was captured last cycle

    // write addr lags rdata_vld by one cycle, so hold the word
    always_ff @(posedge clk) begin
        if (rdata_vld) data_q <= rdata;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (~reset_n) beat_q <= 1'b0;
        else          beat_q <= rdata_vld;
    end

    // both halves are registered, pair them here
    assign wr.addr = waddr;
    assign wr.data = data_q;
    assign wr.vld  = waddr_vld & beat_q;

    assign wr_done = wr.vld;

endmodule : write_stage

`default_nettype wire

//--- src/copy_sequencer.sv
`default_nettype none

module copy_sequencer #(
    parameter int REQ_W = copy_cfg_pkg::REQ_W_DEFAULT
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             init_pulse,
    input  logic [REQ_W-1:0] areq_num,
    input  logic             wr_done,
    output logic             rd_step,
    output logic             finish
);

    typedef enum logic [2:0] {
        S_IDLE  = 3'b001,
        S_ISSUE = 3'b010,
        S_DRAIN = 3'b100
    } state_t;

    state_t           cur_state;
    state_t           nxt_state;
    logic             finish_nxt;
    logic [REQ_W-1:0] limit_q;
    logic             iss_at_limit;
    logic [REQ_W-1:0] wr_count;
    logic             wr_at_limit;
    logic             last_wr;

    always_ff @(posedge clk or negedge reset_n) begin
        if (~reset_n)        limit_q <= '0;
        else if (init_pulse) limit_q <= areq_num;
    end

    // issued reads
    req_counter #(.CNT_W(REQ_W)) u_iss_cnt (
        .clk
    ,   .reset_n
    ,   .clear    (init_pulse)
    ,   .inc      (rd_step)
    ,   .limit    (limit_q)
    ,   .count    ()
    ,   .at_limit (iss_at_limit)
    );

    // completed writes
    req_counter #(.CNT_W(REQ_W)) u_wr_cnt (
        .clk
    ,   .reset_n
    ,   .clear    (init_pulse)
    ,   .inc      (wr_done)
    ,   .limit    (limit_q)
    ,   .count    (wr_count)
    ,   .at_limit (wr_at_limit)
    );

    // beat that brings the write count to the limit
    assign last_wr = wr_done & (wr_count == limit_q - 1'b1);

    assign rd_step = (cur_state == S_ISSUE) & ~iss_at_limit;

    always_comb begin
        nxt_state  = cur_state;
        finish_nxt = 1'b0;
        if (init_pulse) begin
            nxt_state = S_ISSUE;    // restart from any state
        end else begin
            case (cur_state)
                S_ISSUE:
                    if (iss_at_limit & wr_at_limit) begin
                        nxt_state  = S_IDLE;   // zero-length copy
                        finish_nxt = 1'b1;
                    end else if (iss_at_limit) begin
                        nxt_state = S_DRAIN;
                    end
                S_DRAIN:
                    if (last_wr) begin
                        nxt_state  = S_IDLE;
                        finish_nxt = 1'b1;
                    end
                default:
                    nxt_state = S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (~reset_n) begin
            cur_state <= S_IDLE;
            finish    <= 1'b0;
        end else begin
            cur_state <= nxt_state;
            finish    <= finish_nxt;
        end
    end

endmodule : copy_sequencer

`default_nettype wire

//--- src/nested_addr_gen.sv
`default_nettype none

module nested_addr_gen (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            init_pulse,
    input  copy_types_pkg::addr_pattern_t   pattern,
    input  logic                            step,
    output logic [copy_cfg_pkg::ADDR_W-1:0] addr,
    output logic                            addr_vld
);

    copy_types_pkg::addr_pattern_t pat_q;
    logic                          armed;    // a pattern has been loaded
    logic                          step_ok;
    logic                          ripple;

    logic [copy_cfg_pkg::NUM_DIMS-1:0][copy_cfg_pkg::ADDR_W-1:0] idx;
    logic [copy_cfg_pkg::NUM_DIMS-1:0][copy_cfg_pkg::ADDR_W-1:0] off;
    logic [copy_cfg_pkg::NUM_DIMS-1:0]                           wrap;
    logic [copy_cfg_pkg::NUM_DIMS-1:0]                           carry;
    logic [copy_cfg_pkg::ADDR_W-1:0]                             off_sum;

    always_ff @(posedge clk) begin
        if (init_pulse) pat_q <= pattern;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (~reset_n)        armed <= 1'b0;
        else if (init_pulse) armed <= 1'b1;
    end

    assign step_ok = step & armed;

    // last index of a dim, size 0/1 never moves
    always_comb begin
        for (int d = 0; d < copy_cfg_pkg::NUM_DIMS; d++) begin
            wrap[d] = (pat_q.size[d] <= 1) | (idx[d] == pat_q.size[d] - 1'b1);
        end
    end

    // odometer carry chain from dim 0 up
    always_comb begin
        ripple = step_ok;
        for (int d = 0; d < copy_cfg_pkg::NUM_DIMS; d++) begin
            carry[d] = ripple;
            ripple   = ripple & wrap[d];
        end
    end

    always_comb begin
        off_sum = pat_q.base;
        for (int d = 0; d < copy_cfg_pkg::NUM_DIMS; d++) begin
            off_sum = off_sum + off[d];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (~reset_n) begin
            idx <= '0;
            off <= '0;
        end else if (init_pulse) begin
            idx <= '0;
            off <= '0;
        end else begin
            for (int d = 0; d < copy_cfg_pkg::NUM_DIMS; d++) begin
                if (carry[d] & wrap[d]) begin
                    idx[d] <= '0;
                    off[d] <= '0;
                end else if (carry[d]) begin
                    idx[d] <= idx[d] + 1'b1;
                    off[d] <= off[d] + pat_q.stride[d];  // running index*stride
                end
            end
        end
    end

    // address of the current indices, before they advance
    always_ff @(posedge clk) begin
        if (step_ok) addr <= off_sum;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (~reset_n)        addr_vld <= 1'b0;
        else if (init_pulse) addr_vld <= 1'b0;
        else                 addr_vld <= step_ok;
    end

endmodule : nested_addr_gen

`default_nettype wire

//--- src/req_counter.sv
`default_nettype none

module req_counter #(
    parameter int CNT_W = copy_cfg_pkg::REQ_W_DEFAULT
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             clear,
    input  logic             inc,
    input  logic [CNT_W-1:0] limit,
    output logic [CNT_W-1:0] count,
    output logic             at_limit
);

    // clear wins over inc
    always_ff @(posedge clk or negedge reset_n) begin
        if (~reset_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (inc) begin
            count <= count + 1'b1;
        end
    end

    assign at_limit = (count == limit);

endmodule : req_counter

`default_nettype wire

//--- src/copy_types_pkg.sv
`default_nettype none

package copy_types_pkg;

    // base plus size/stride per dimension
    typedef struct packed {
        logic [copy_cfg_pkg::ADDR_W-1:0]                             base;
        logic [copy_cfg_pkg::NUM_DIMS-1:0][copy_cfg_pkg::ADDR_W-1:0] size;
        logic [copy_cfg_pkg::NUM_DIMS-1:0][copy_cfg_pkg::ADDR_W-1:0] stride;
    } addr_pattern_t;

    // read request toward memory
    typedef struct packed {
        logic [copy_cfg_pkg::ADDR_W-1:0] addr;
        logic                            vld;
    } rd_req_t;

    // write beat, no back-pressure
    typedef struct packed {
        logic [copy_cfg_pkg::ADDR_W-1:0] addr;
        logic [copy_cfg_pkg::DATA_W-1:0] data;
        logic                            vld;
    } wr_beat_t;

endpackage : copy_types_pkg

`default_nettype wire

//--- src/copy_cfg_pkg.sv
`default_nettype none

package copy_cfg_pkg;

    // byte addressed, wraps at this width
    localparam int ADDR_W = 16;

    // one data word moves per beat
    localparam int DATA_BYTES = 64;
    localparam int DATA_W     = DATA_BYTES * 8;

    // dimensions per address pattern, dim 0 runs fastest
    localparam int NUM_DIMS = 6;

    // request count width unless the top level overrides it
    localparam int REQ_W_DEFAULT = 16;

endpackage : copy_cfg_pkg

`default_nettype wire
